/* rv_front.f */
+incdir+hdl
+incdir+test
hdl/rv_front_pkg.sv
hdl/if_fetch.sv
hdl/ir_fifo.sv
hdl/imm_extractor.sv
hdl/id_stage.sv
hdl/rv_front.sv
test/tb_clock_gen.sv
test/tb_rv_front.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_front testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f rv_front.f \
    --top-module tb_rv_front -Mdir "$BUILD_DIR" -o tb_rv_front
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/tb_rv_front" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* test/tb_rv_front_model.svh */
`ifndef TB_RV_FRONT_MODEL_SVH
`define TB_RV_FRONT_MODEL_SVH

// The ten major opcodes the front end knows
localparam logic [6:0] KNOWN_OPS [10] = '{
    `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR, `RV_OP_BRANCH,
    `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_IMM, `RV_OP_REG, `RV_OP_SYSTEM
};

function automatic bit is_known_op(input logic [6:0] op);
    foreach (KNOWN_OPS[i]) begin
        if (KNOWN_OPS[i] == op) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// Sign-extend the low bits of v
function automatic logic [31:0] sign_ext(input logic [31:0] v, input int bits);
    logic signed [31:0] s;
    s = v << (32 - bits);
    return s >>> (32 - bits);
endfunction

function automatic logic [31:0] ref_imm(input logic [31:0] ir);
    logic [31:0] i_form;
    i_form = sign_ext({20'b0, ir[31:20]}, 12);
    case (ir[6:0])
        `RV_OP_LUI, `RV_OP_AUIPC: return {ir[31:12], 12'h000};
        `RV_OP_JAL:    return sign_ext({11'b0, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0}, 21);
        `RV_OP_BRANCH: return sign_ext({19'b0, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0}, 13);
        `RV_OP_STORE:  return sign_ext({20'b0, ir[31:25], ir[11:7]}, 12);
        `RV_OP_JALR, `RV_OP_LOAD: return i_form;
        // Shifts take an unsigned shamt
        `RV_OP_IMM:    return (ir[13:12] == 2'b01) ? {27'b0, ir[24:20]} : i_form;
        `RV_OP_SYSTEM: return {27'b0, ir[19:15]};
        default:       return 32'b0;
    endcase
endfunction

function automatic rv_front_pkg::decoded_t ref_decode(input logic [31:0] pc,
                                                      input logic [31:0] ir);
    rv_front_pkg::decoded_t d;
    logic writes_rd;
    logic csr_op;
    d.pc       = pc;
    d.rs1      = ir[19:15];
    d.rs2      = ir[24:20];
    d.rd       = ir[11:7];
    d.opcode   = ir[6:0];
    d.funct3   = ir[14:12];
    d.funct7   = ir[31:25];
    d.csr_addr = ir[31:20];
    d.imm      = ref_imm(ir);
    csr_op     = (ir[6:0] == `RV_OP_SYSTEM) && (ir[14:12] != 3'b000);
    writes_rd  = csr_op || (ir[6:0] inside {`RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_IMM,
                 `RV_OP_REG, `RV_OP_LOAD, `RV_OP_JAL, `RV_OP_JALR});
    d.wr_reg_n = !(writes_rd && (ir[11:7] != 5'd0));
    d.wr_csr_n = !csr_op;
    return d;
endfunction

// Mix of known opcodes, unknown opcodes, rd of x0 and ecall-type words
function automatic logic [31:0] random_instr();
    logic [31:0] w;
    int unsigned pick;
    w    = $urandom;
    pick = $urandom % 13;
    if (pick < 10) begin
        w[6:0] = KNOWN_OPS[pick];
    end else if (pick == 10) begin
        while (is_known_op(w[6:0])) w[6:0] = w[6:0] + 7'd1;
    end else if (pick == 11) begin
        w[6:0]  = KNOWN_OPS[$urandom % 10];
        w[11:7] = 5'd0;
    end else begin
        w[6:0]   = `RV_OP_SYSTEM;
        w[14:12] = 3'b000;
    end
    return w;
endfunction

`endif

/* test/tb_rv_front.sv */
`timescale 1ns/1ns
`include "rv_front_params.svh"

module tb_rv_front;

    localparam int NUM_BUNDLES = 300;
    localparam int MAX_CYCLES  = 20000;

    logic                   clk;
    logic                   rst;
    rv_front_pkg::wb_req_t  wb_req;
    logic [31:0]            wb_dat;
    logic                   wb_ack;
    rv_front_pkg::decoded_t dec;
    logic                   dec_valid;
    logic                   dec_ready;
    logic [31:0]            imem [256];
    int unsigned            seed;
    int unsigned            waits;
    int unsigned            drive_cycles = 0;
    int                     mismatch_errors = 0;
    int                     protocol_errors = 0;
    int                     timeout_errors = 0;
    int                     fetches = 0;
    int                     bundles = 0;
    logic [31:0]            exp_fetch_adr = `RV_RESET_PC;
    logic [31:0]            exp_pc = `RV_RESET_PC;
    bit                     busy = 1'b0;
    bit                     stalled = 1'b0;
    rv_front_pkg::decoded_t held_dec;

    `include "tb_rv_front_model.svh"

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clock_gen (.clk(clk), .rst(rst));

    rv_front u_rv_front (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_dat    (wb_dat),
        .wb_ack    (wb_ack),
        .dec       (dec),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready)
    );

    // Wishbone slave with 0 to 3 wait states per cycle
    task automatic serve_bus();
        if (wb_ack) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
            assert (!wb_req.stb) else begin
                protocol_errors++;
                $display("Strobe still high in the cycle after ack at %0t", $time);
            end
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!busy) begin
                busy  = 1'b1;
                waits = $urandom % 4;
            end
            assert (wb_req.adr === exp_fetch_adr && !wb_req.we) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: fetch address %h we %b, expected %h", $time,
                         wb_req.adr, wb_req.we, exp_fetch_adr);
            end
            if (waits == 0) begin
                wb_dat = imem[wb_req.adr[9:2]];
                wb_ack = 1'b1;
                fetches++;
                exp_fetch_adr = exp_fetch_adr + 32'd4;
            end else begin
                waits--;
            end
        end else begin
            assert (!busy) else begin
                protocol_errors++;
                $display("Bus cycle dropped before ack at %0t", $time);
            end
        end
    endtask

    task automatic check_bundle();
        rv_front_pkg::decoded_t expected;
        expected = ref_decode(exp_pc, imem[exp_pc[9:2]]);
        assert (dec === expected) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: pc %h ir %h imm %h wr %b%b, expected pc %h imm %h wr %b%b",
                     $time, dec.pc, imem[exp_pc[9:2]], dec.imm, dec.wr_reg_n, dec.wr_csr_n,
                     expected.pc, expected.imm, expected.wr_reg_n, expected.wr_csr_n);
        end
        exp_pc = exp_pc + 32'd4;
        bundles++;
    endtask

    // Inputs change 1 ns after the rising edge
    always @(posedge clk) begin
        logic        in_reset;
        int unsigned ready_pct;
        in_reset = rst;
        #1;
        if (in_reset) begin
            wb_ack    = 1'b0;
            busy      = 1'b0;
            dec_ready = 1'b0;
            assert (!wb_req.cyc && !wb_req.stb && !dec_valid) else begin
                protocol_errors++;
                $display("Bus or decode output active during reset at %0t", $time);
            end
        end else begin
            // Long stretches of rare ready fill the FIFO and stall fetch
            ready_pct = ((drive_cycles % 128) < 48) ? 10 : 75;
            dec_ready = ($urandom % 100) < ready_pct;
            drive_cycles++;
            serve_bus();
        end
    end

    // Outputs sampled mid-cycle, a transfer happens on the next edge
    always @(negedge clk) begin
        if (!rst) begin
            if (stalled) begin
                assert (dec_valid === 1'b1 && dec === held_dec) else begin
                    mismatch_errors++;
                    $display("Mismatch at %0t: decode output changed while stalled", $time);
                end
            end
            if (fetches == 0) begin
                assert (dec_valid === 1'b0) else begin
                    protocol_errors++;
                    $display("Decode output valid before any word was fetched at %0t", $time);
                end
            end
            if (dec_valid === 1'b1 && dec_ready === 1'b1) begin
                check_bundle();
            end
            stalled  = (dec_valid === 1'b1) && (dec_ready === 1'b0);
            held_dec = dec;
        end
    end

    initial begin
        int cycles;
        seed = 32'he17b9fc3;
        void'($urandom(seed));
        for (int i = 0; i < 256; i++) begin
            imem[i] = random_instr();
        end
        wb_ack    = 1'b0;
        wb_dat    = 32'b0;
        dec_ready = 1'b0;
        cycles = 0;
        while (rst !== 1'b0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            timeout_errors++;
            $display("Timeout: reset was never released");
        end
        cycles = 0;
        while (timeout_errors == 0 && bundles < NUM_BUNDLES && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (timeout_errors == 0 && bundles < NUM_BUNDLES) begin
            timeout_errors++;
            $display("Timeout: only %0d of %0d bundles arrived", bundles, NUM_BUNDLES);
        end
        $display("Errors: %0d mismatch, %0d protocol, %0d timeout",
                 mismatch_errors, protocol_errors, timeout_errors);
        if (mismatch_errors + protocol_errors + timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after the last reset edge, like any other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* hdl/rv_front.sv */
`timescale 1ns/1ns
`include "rv_front_params.svh"

module rv_front (
    input  logic                   clk,
    input  logic                   rst,
    output rv_front_pkg::wb_req_t  wb_req,
    input  logic [31:0]            wb_dat,
    input  logic                   wb_ack,
    output rv_front_pkg::decoded_t dec,
    output logic                   dec_valid,
    input  logic                   dec_ready
);

    logic                      push;
    rv_front_pkg::fetch_item_t push_item;
    logic                      full;
    logic                      pop;
    rv_front_pkg::fetch_item_t head;
    logic                      empty;

    // Wishbone fetch
    if_fetch u_if_fetch (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_dat    (wb_dat),
        .wb_ack    (wb_ack),
        .push      (push),
        .push_item (push_item),
        .full      (full)
    );

    // Instruction buffer between fetch and decode
    ir_fifo #(
        .item_t (rv_front_pkg::fetch_item_t),
        .DEPTH  (`RV_FIFO_DEPTH)
    ) u_ir_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_item (push_item),
        .full      (full),
        .pop       (pop),
        .head      (head),
        .empty     (empty)
    );

    id_stage u_id_stage (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .dec       (dec),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready)
    );

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/1ns
`include "rv_front_params.svh"

module id_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  rv_front_pkg::fetch_item_t head,
    input  logic                      empty,
    output logic                      pop,
    output rv_front_pkg::decoded_t    dec,
    output logic                      dec_valid,
    input  logic                      dec_ready
);

    logic [31:0]             ir;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [4:0]              rd;
    rv_front_pkg::imm_kind_e imm_kind;
    logic [31:0]             imm;
    rv_front_pkg::decoded_t  dec_next;
    logic                    load;

    function automatic rv_front_pkg::imm_kind_e imm_kind_from(
        input logic [6:0] op,
        input logic [2:0] f3
    );
        case (op)
            `RV_OP_LUI,
            `RV_OP_AUIPC:  return rv_front_pkg::IMM_U;
            `RV_OP_JAL:    return rv_front_pkg::IMM_J;
            `RV_OP_JALR,
            `RV_OP_LOAD:   return rv_front_pkg::IMM_I;
            `RV_OP_BRANCH: return rv_front_pkg::IMM_B;
            `RV_OP_STORE:  return rv_front_pkg::IMM_S;
            `RV_OP_IMM: begin
                // SLLI, SRLI and SRAI carry a shamt
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    return rv_front_pkg::IMM_SHAMT;
                end
                return rv_front_pkg::IMM_I;
            end
            `RV_OP_SYSTEM: return rv_front_pkg::IMM_CSR;
            default:       return rv_front_pkg::IMM_NONE;
        endcase
    endfunction

    // Whitelist of opcodes that write rd
    function automatic logic wr_reg_n_from(
        input logic [6:0] op,
        input logic [4:0] rd_f,
        input logic [2:0] f3
    );
        logic allowed;
        case (op)
            `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_IMM, `RV_OP_REG,
            `RV_OP_LOAD, `RV_OP_JAL, `RV_OP_JALR: allowed = 1'b1;
            `RV_OP_SYSTEM: allowed = (f3 != 3'b000);
            default:       allowed = 1'b0;
        endcase
        // x0 is hardwired to zero
        return (rd_f == 5'd0) || !allowed;
    endfunction

    // ecall and ebreak share the opcode but have funct3 zero
    function automatic logic wr_csr_n_from(
        input logic [6:0] op,
        input logic [2:0] f3
    );
        return !((op == `RV_OP_SYSTEM) && (f3 != 3'b000));
    endfunction

    assign ir       = head.ir;
    assign opcode   = ir[6:0];
    assign funct3   = ir[14:12];
    assign rd       = ir[11:7];
    assign imm_kind = imm_kind_from(opcode, funct3);

    imm_extractor u_imm_extractor (
        .ir       (ir),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    always_comb begin
        dec_next.pc       = head.pc;
        dec_next.rs1      = ir[19:15];
        dec_next.rs2      = ir[24:20];
        dec_next.rd       = rd;
        dec_next.opcode   = opcode;
        dec_next.funct3   = funct3;
        dec_next.funct7   = ir[31:25];
        dec_next.csr_addr = ir[31:20];
        dec_next.imm      = imm;
        dec_next.wr_reg_n = wr_reg_n_from(opcode, rd, funct3);
        dec_next.wr_csr_n = wr_csr_n_from(opcode, funct3);
    end

    // Load when a word is waiting and the output slot is free or draining
    assign load = !empty && (!dec_valid || dec_ready);
    assign pop  = load;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    // Bundle holds while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            dec <= dec_next;
        end
    end

endmodule

/* hdl/imm_extractor.sv */
`timescale 1ns/1ns

module imm_extractor (
    input  logic [31:0]             ir,
    input  rv_front_pkg::imm_kind_e imm_kind,
    output logic [31:0]             imm
);

    always_comb begin
        case (imm_kind)
            rv_front_pkg::IMM_I: begin
                imm = {{20{ir[31]}}, ir[31:20]};
            end
            rv_front_pkg::IMM_B: begin
                // Branch offsets are always even
                imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            rv_front_pkg::IMM_S: begin
                imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            end
            rv_front_pkg::IMM_U: begin
                imm = {ir[31:12], 12'b0};
            end
            rv_front_pkg::IMM_J: begin
                imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            rv_front_pkg::IMM_SHAMT: begin
                // Shift amount, unsigned
                imm = {27'b0, ir[24:20]};
            end
            rv_front_pkg::IMM_CSR: begin
                // uimm sits in the rs1 field
                imm = {27'b0, ir[19:15]};
            end
            default: begin
                imm = 32'b0;
            end
        endcase
    end

endmodule

/* hdl/ir_fifo.sv */
`timescale 1ns/1ns

module ir_fifo #(
    parameter type item_t = rv_front_pkg::fetch_item_t,
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  item_t push_item,
    output logic  full,
    input  logic  pop,
    output item_t head,
    output logic  empty
);

    // Keeps pointers at least one bit wide for a single entry
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t           mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hdl/if_fetch.sv */
`timescale 1ns/1ns
`include "rv_front_params.svh"

module if_fetch (
    input  logic                      clk,
    input  logic                      rst,
    output rv_front_pkg::wb_req_t     wb_req,
    input  logic [31:0]               wb_dat,
    input  logic                      wb_ack,
    output logic                      push,
    output rv_front_pkg::fetch_item_t push_item,
    input  logic                      full
);

    typedef enum logic {
        ST_IDLE,
        ST_BUS
    } fetch_state_e;

    fetch_state_e state;
    logic [31:0]  pc;

    // One bus cycle at a time, so nothing is in flight while idle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Only start when the FIFO can take the word
                    if (!full) begin
                        state <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_ack) begin
                        // stb drops for at least one cycle after ack
                        state <= ST_IDLE;
                        pc    <= pc + 32'd4;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Bus request held stable for the whole cycle
    always_comb begin
        wb_req.cyc = (state == ST_BUS);
        wb_req.stb = (state == ST_BUS);
        wb_req.we  = 1'b0;
        wb_req.adr = pc;
    end

    // Word goes into the FIFO on the ack edge
    always_comb begin
        push         = (state == ST_BUS) && wb_ack;
        push_item.pc = pc;
        push_item.ir = wb_dat;
    end

endmodule

/* hdl/rv_front_pkg.sv */
package rv_front_pkg;

    // Immediate formats recognised by the decoder
    typedef enum logic [2:0] {
        IMM_I     = 3'b000,
        IMM_B     = 3'b001,
        IMM_S     = 3'b010,
        IMM_U     = 3'b011,
        IMM_J     = 3'b100,
        IMM_SHAMT = 3'b101,
        IMM_CSR   = 3'b110,
        IMM_NONE  = 3'b111
    } imm_kind_e;

    // One fetched word with the address it came from
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ir;
    } fetch_item_t;

    // Decoded instruction handed to the EX stage
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] csr_addr;
        logic [31:0] imm;
        // Active low, 0 means write
        logic        wr_reg_n;
        logic        wr_csr_n;
    } decoded_t;

    // Wishbone classic master request
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
    } wb_req_t;

endpackage

/* hdl/rv_front_params.svh */
`ifndef RV_FRONT_PARAMS_SVH
`define RV_FRONT_PARAMS_SVH

// RV32I major opcodes
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
// Shared by CSR access, ecall and ebreak
`define RV_OP_SYSTEM 7'b1110011

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Instruction buffer entries
`define RV_FIFO_DEPTH 4

`endif
